//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = afu_control_tb
FLIST     = flist.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FLIST)) logic/afu_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
+incdir+logic
logic/cmd_pkg.sv
logic/rsp_pkg.sv
logic/command_queue.sv
logic/command_arbiter.sv
logic/tag_table.sv
logic/response_router.sv
logic/response_queue.sv
logic/afu_control.sv
test/afu_control_asserts.sv
test/afu_control_tb.sv

//--- logic/afu_cfg.svh
// shared sizes; queue depths and the tag count must be powers of two, and AFU_RSP_DEPTH >= AFU_NUM_TAGS
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// command side
////////////////////////////////////////////////////////////////////////////

// read, write and wed sources
`define AFU_NUM_SOURCES 3
`define AFU_CMD_DEPTH   8

////////////////////////////////////////////////////////////////////////////
// host side
////////////////////////////////////////////////////////////////////////////

// tags double as host credits
`define AFU_NUM_TAGS    8
`define AFU_TAG_WIDTH   3
`define AFU_ADDR_WIDTH  16

// one slot per outstanding tag, so response queues never overflow
`define AFU_RSP_DEPTH   8

`endif

//--- logic/afu_control.sv
// control core top; host room equals AFU_NUM_TAGS, the host must answer every tag exactly once
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module afu_control (
	input  logic                              clock,
	input  logic                              rstn,
	input  logic                              enabled,
	input  cmd_pkg::command_line_t            cmd_in [`AFU_NUM_SOURCES],
	output logic [`AFU_NUM_SOURCES-1:0]       cmd_ready,
	output cmd_pkg::host_command_t            host_command,
	input  rsp_pkg::host_response_t           host_response,
	output rsp_pkg::response_line_t           rsp_out [`AFU_NUM_SOURCES],
	input  logic [`AFU_NUM_SOURCES-1:0]       rsp_ready
);

	cmd_pkg::command_line_t       heads [`AFU_NUM_SOURCES];
	logic [`AFU_NUM_SOURCES-1:0]  not_empty;
	logic [`AFU_NUM_SOURCES-1:0]  pop;
	logic                         tag_available;
	logic [`AFU_TAG_WIDTH-1:0]    free_tag;
	logic                         issue;
	cmd_pkg::source_id_t          issue_source;
	logic [`AFU_ADDR_WIDTH-1:0]   issue_addr;
	logic [`AFU_TAG_WIDTH-1:0]    lookup_tag;
	rsp_pkg::tag_entry_t          lookup_entry;
	logic                         tag_release;
	logic [`AFU_NUM_SOURCES-1:0]  push;
	rsp_pkg::response_line_t      line_out;

////////////////////////////////////////////////////////////////////////////
// command path
////////////////////////////////////////////////////////////////////////////

	for (genvar s = 0; s < `AFU_NUM_SOURCES; s++) begin : g_cmd
		command_queue i_command_queue (
			.clock    (clock       ),
			.rstn     (rstn        ),
			.line_in  (cmd_in[s]   ),
			.cmd_ready(cmd_ready[s]),
			.pop      (pop[s]      ),
			.head     (heads[s]    ),
			.not_empty(not_empty[s])
		);
	end

	command_arbiter i_command_arbiter (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.enabled      (enabled      ),
		.heads        (heads        ),
		.not_empty    (not_empty    ),
		.pop          (pop          ),
		.tag_available(tag_available),
		.free_tag     (free_tag     ),
		.issue        (issue        ),
		.issue_source (issue_source ),
		.issue_addr   (issue_addr   ),
		.host_command (host_command )
	);

	tag_table i_tag_table (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.issue        (issue        ),
		.issue_source (issue_source ),
		.issue_addr   (issue_addr   ),
		.tag_available(tag_available),
		.free_tag     (free_tag     ),
		.lookup_tag   (lookup_tag   ),
		.lookup_entry (lookup_entry ),
		.tag_release  (tag_release  )
	);

////////////////////////////////////////////////////////////////////////////
// response path
////////////////////////////////////////////////////////////////////////////

	response_router i_response_router (
		.clock        (clock        ),
		.rstn         (rstn         ),
		.enabled      (enabled      ),
		.host_response(host_response),
		.lookup_tag   (lookup_tag   ),
		.lookup_entry (lookup_entry ),
		.tag_release  (tag_release  ),
		.push         (push         ),
		.line_out     (line_out     )
	);

	for (genvar s = 0; s < `AFU_NUM_SOURCES; s++) begin : g_rsp
		response_queue i_response_queue (
			.clock    (clock       ),
			.rstn     (rstn        ),
			.push     (push[s]     ),
			.line_in  (line_out    ),
			.rsp_ready(rsp_ready[s]),
			.rsp_out  (rsp_out[s]  )
		);
	end

endmodule

`default_nettype wire

//--- logic/cmd_pkg.sv
// command side types; source_id_t is sized from AFU_NUM_SOURCES, compile before rsp_pkg
`default_nettype none

`include "afu_cfg.svh"

package cmd_pkg;

	// only line-granular reads and writes
	typedef enum logic [1:0] {
		CMD_READ_LINE  = 2'd1,
		CMD_WRITE_LINE = 2'd2
	} cmd_code_t;

	typedef logic [$clog2(`AFU_NUM_SOURCES)-1:0] source_id_t;

	// what a source pushes into its queue
	typedef struct packed {
		logic                       valid;
		cmd_code_t                  code;
		logic [`AFU_ADDR_WIDTH-1:0] address;
	} command_line_t;

	// word issued to the host, tag taken from the pool
	typedef struct packed {
		logic                       valid;
		cmd_code_t                  code;
		logic [`AFU_TAG_WIDTH-1:0]  tag;
		logic [`AFU_ADDR_WIDTH-1:0] address;
	} host_command_t;

endpackage

`default_nettype wire

//--- logic/command_arbiter.sv
// round-robin issue stage; grants only with enabled high and a free tag, host cannot stall
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module command_arbiter (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enabled,
	input  cmd_pkg::command_line_t             heads [`AFU_NUM_SOURCES],
	input  logic [`AFU_NUM_SOURCES-1:0]        not_empty,
	output logic [`AFU_NUM_SOURCES-1:0]        pop,
	input  logic                               tag_available,
	input  logic [`AFU_TAG_WIDTH-1:0]          free_tag,
	output logic                               issue,
	output cmd_pkg::source_id_t                issue_source,
	output logic [`AFU_ADDR_WIDTH-1:0]         issue_addr,
	output cmd_pkg::host_command_t             host_command
);

	cmd_pkg::source_id_t last;
	cmd_pkg::source_id_t sel;
	logic                found;
	logic                grant;

////////////////////////////////////////////////////////////////////////////
// pick the next requester after the last winner
////////////////////////////////////////////////////////////////////////////

	always_comb begin
		int idx;
		found = 1'b0;
		sel   = last;
		for (int k = 1; k <= `AFU_NUM_SOURCES; k++) begin
			idx = (int'(last) + k) % `AFU_NUM_SOURCES;
			if (!found && not_empty[idx] && heads[idx].valid) begin
				found = 1'b1;
				sel   = cmd_pkg::source_id_t'(idx);
			end
		end
	end

	assign grant        = found && enabled && tag_available;
	assign issue        = grant;
	assign issue_source = sel;
	assign issue_addr   = heads[sel].address;

	always_comb begin
		pop = '0;
		if (grant) pop[sel] = 1'b1;
	end

////////////////////////////////////////////////////////////////////////////
// issue register, one-cycle pulse to the host
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			// source 0 wins first after reset
			last         <= cmd_pkg::source_id_t'(`AFU_NUM_SOURCES - 1);
			host_command <= '0;
		end else begin
			host_command.valid <= grant;
			if (grant) begin
				last                 <= sel;
				host_command.code    <= heads[sel].code;
				host_command.tag     <= free_tag;
				host_command.address <= heads[sel].address;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/command_queue.sv
// per-source command FIFO; AFU_CMD_DEPTH must be a power of two, pop is ignored while empty
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module command_queue (
	input  logic                   clock,
	input  logic                   rstn,
	input  cmd_pkg::command_line_t line_in,
	output logic                   cmd_ready,
	input  logic                   pop,
	output cmd_pkg::command_line_t head,
	output logic                   not_empty
);

	localparam int PTR_W = $clog2(`AFU_CMD_DEPTH);
	localparam int CNT_W = $clog2(`AFU_CMD_DEPTH + 1);

	cmd_pkg::command_line_t mem [`AFU_CMD_DEPTH];
	logic [PTR_W-1:0]       rd_ptr;
	logic [PTR_W-1:0]       wr_ptr;
	logic [CNT_W-1:0]       count;
	logic                   do_push;
	logic                   do_pop;

	assign cmd_ready = (count != CNT_W'(`AFU_CMD_DEPTH));
	assign not_empty = (count != '0);
	assign do_push   = line_in.valid && cmd_ready;
	assign do_pop    = pop && not_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap on their own
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) mem[wr_ptr] <= line_in;
	end

	always_comb begin
		head       = mem[rd_ptr];
		head.valid = not_empty;
	end

endmodule

`default_nettype wire

//--- logic/response_queue.sv
// per-source response FIFO; AFU_RSP_DEPTH must be a power of two, push while full is dropped
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module response_queue (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    push,
	input  rsp_pkg::response_line_t line_in,
	input  logic                    rsp_ready,
	output rsp_pkg::response_line_t rsp_out
);

	localparam int PTR_W = $clog2(`AFU_RSP_DEPTH);
	localparam int CNT_W = $clog2(`AFU_RSP_DEPTH + 1);

	rsp_pkg::response_line_t mem [`AFU_RSP_DEPTH];
	logic [PTR_W-1:0]        rd_ptr;
	logic [PTR_W-1:0]        wr_ptr;
	logic [CNT_W-1:0]        count;
	logic                    do_push;
	logic                    do_pop;

	assign do_push = push && (count != CNT_W'(`AFU_RSP_DEPTH));
	assign do_pop  = rsp_ready && (count != '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop) rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) mem[wr_ptr] <= line_in;
	end

	// head stays put until the sink takes it
	always_comb begin
		rsp_out       = mem[rd_ptr];
		rsp_out.valid = (count != '0);
	end

endmodule

`default_nettype wire

//--- logic/response_router.sv
// response stage; every code is forwarded, error set for all but done, responses dropped while disabled
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module response_router (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  rsp_pkg::host_response_t      host_response,
	output logic [`AFU_TAG_WIDTH-1:0]    lookup_tag,
	input  rsp_pkg::tag_entry_t          lookup_entry,
	output logic                         tag_release,
	output logic [`AFU_NUM_SOURCES-1:0]  push,
	output rsp_pkg::response_line_t      line_out
);

	rsp_pkg::host_response_t rsp_q;
	logic                    error_q;

	// capture the host response and decode its code
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rsp_q   <= '0;
			error_q <= 1'b0;
		end else begin
			rsp_q.valid <= enabled && host_response.valid;
			if (enabled && host_response.valid) begin
				rsp_q.tag  <= host_response.tag;
				rsp_q.code <= host_response.code;
				error_q    <= (host_response.code != rsp_pkg::RSP_DONE);
			end
		end
	end

	// tag lookup happens in the registered cycle
	assign lookup_tag  = rsp_q.tag;
	assign tag_release = rsp_q.valid;

	always_comb begin
		for (int s = 0; s < `AFU_NUM_SOURCES; s++) begin
			push[s] = rsp_q.valid && (lookup_entry.source == cmd_pkg::source_id_t'(s));
		end
	end

	always_comb begin
		line_out.valid   = rsp_q.valid;
		line_out.code    = rsp_q.code;
		line_out.error   = error_q;
		line_out.address = lookup_entry.address;
	end

endmodule

`default_nettype wire

//--- logic/rsp_pkg.sv
// response side types; uses cmd_pkg::source_id_t, so cmd_pkg must be compiled first
`default_nettype none

`include "afu_cfg.svh"

package rsp_pkg;

	// host response codes, only done counts as success
	typedef enum logic [3:0] {
		RSP_DONE    = 4'd0,
		RSP_AERROR  = 4'd1,
		RSP_DERROR  = 4'd2,
		RSP_NLOCK   = 4'd3,
		RSP_NRES    = 4'd4,
		RSP_FAILED  = 4'd5,
		RSP_PAGED   = 4'd6,
		RSP_FAULT   = 4'd7,
		RSP_FLUSHED = 4'd8
	} rsp_code_t;

	typedef struct packed {
		logic                      valid;
		logic [`AFU_TAG_WIDTH-1:0] tag;
		rsp_code_t                 code;
	} host_response_t;

	typedef struct packed {
		logic                       valid;
		rsp_code_t                  code;
		logic                       error;
		logic [`AFU_ADDR_WIDTH-1:0] address;
	} response_line_t;

	// owner of an outstanding tag
	typedef struct packed {
		cmd_pkg::source_id_t        source;
		logic [`AFU_ADDR_WIDTH-1:0] address;
	} tag_entry_t;

endpackage

`default_nettype wire

//--- logic/tag_table.sv
// tag pool and owner table; issue only while tag_available, release only for a busy tag
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module tag_table (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       issue,
	input  cmd_pkg::source_id_t        issue_source,
	input  logic [`AFU_ADDR_WIDTH-1:0] issue_addr,
	output logic                       tag_available,
	output logic [`AFU_TAG_WIDTH-1:0]  free_tag,
	input  logic [`AFU_TAG_WIDTH-1:0]  lookup_tag,
	output rsp_pkg::tag_entry_t        lookup_entry,
	input  logic                       tag_release
);

	logic [`AFU_NUM_TAGS-1:0] busy;
	rsp_pkg::tag_entry_t      entries [`AFU_NUM_TAGS];

////////////////////////////////////////////////////////////////////////////
// free tag search
////////////////////////////////////////////////////////////////////////////

	assign tag_available = ~&busy;

	// lowest free tag wins
	always_comb begin
		free_tag = '0;
		for (int t = `AFU_NUM_TAGS - 1; t >= 0; t--) begin
			if (!busy[t]) free_tag = `AFU_TAG_WIDTH'(t);
		end
	end

////////////////////////////////////////////////////////////////////////////
// busy bits
////////////////////////////////////////////////////////////////////////////

	// issue and release never hit the same tag in one cycle,
	// free_tag is idle and lookup_tag is outstanding
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= '0;
		end else begin
			if (tag_release) busy[lookup_tag] <= 1'b0;
			if (issue) busy[free_tag] <= 1'b1;
		end
	end

////////////////////////////////////////////////////////////////////////////
// owner table
////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (issue) begin
			entries[free_tag].source  <= issue_source;
			entries[free_tag].address <= issue_addr;
		end
	end

	// combinational read for the router
	assign lookup_entry = entries[lookup_tag];

endmodule

`default_nettype wire

//--- test/afu_control_asserts.sv
// bound into afu_control; busy must be connected to the tag table's busy vector
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module afu_control_asserts (
	input logic                              clock,
	input logic                              rstn,
	input logic [`AFU_NUM_TAGS-1:0]          busy,
	input cmd_pkg::host_command_t            host_command,
	input rsp_pkg::response_line_t           rsp_out [`AFU_NUM_SOURCES],
	input logic [`AFU_NUM_SOURCES-1:0]       rsp_ready
);

	// a host command needs a free tag in its grant cycle
	no_issue_when_full: assert property (@(posedge clock) disable iff (!rstn)
		host_command.valid |-> !(&$past(busy)))
		else $error("host command issued while every tag was busy");

	// the issued tag was idle when it was granted
	no_busy_tag_reuse: assert property (@(posedge clock) disable iff (!rstn)
		host_command.valid |->
			((($past(busy) >> host_command.tag) & `AFU_NUM_TAGS'(1)) == '0))
		else $error("host command carries a tag that was still busy");

	for (genvar s = 0; s < `AFU_NUM_SOURCES; s++) begin : g_hold
		rsp_held_stable: assert property (@(posedge clock) disable iff (!rstn)
			rsp_out[s].valid && !rsp_ready[s] |=> $stable(rsp_out[s]))
			else $error("response head changed while held");
	end

endmodule

`default_nettype wire

//--- test/afu_control_tb.sv
// host model answers every tag once; addresses carry the source in bits 13:12
`timescale 1ns/100ps
`default_nettype none

`include "afu_cfg.svh"

module afu_control_tb;

	localparam int RESET_CYCLES   = 16;
	localparam int NUM_ROWS       = 18;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + RESET_CYCLES;

	typedef struct packed {
		logic [1:0]          source;
		cmd_pkg::cmd_code_t  code;
		logic [15:0]         address;
		rsp_pkg::rsp_code_t  rsp_code;
		logic [3:0]          delay;
		logic                hold;
	} row_t;

	logic                              clock;
	logic                              rstn;
	logic                              enabled;
	cmd_pkg::command_line_t            cmd_in [`AFU_NUM_SOURCES];
	logic [`AFU_NUM_SOURCES-1:0]       cmd_ready;
	cmd_pkg::host_command_t            host_command;
	rsp_pkg::host_response_t           host_response;
	rsp_pkg::response_line_t           rsp_out [`AFU_NUM_SOURCES];
	logic [`AFU_NUM_SOURCES-1:0]       rsp_ready;

	row_t                    table_rows [NUM_ROWS];
	cmd_pkg::command_line_t  exp_cmds [$];
	rsp_pkg::response_line_t exp_rsps [$];
	rsp_pkg::rsp_code_t      code_of [logic [15:0]];
	int                      delay_of [logic [15:0]];
	logic [2:0]              pend_tag [$];
	logic [15:0]             pend_addr [$];
	int                      pend_due [$];
	logic [`AFU_NUM_TAGS-1:0] outstanding;
	logic [7:0]              lfsr;
	int                      cycle;
	int                      issued_count;
	int                      last_src;
	logic                    have_last;
	logic                    silent;
	logic                    rr_check;
	logic                    quiet;
	logic                    inject_bogus;

	afu_control i_afu_control (.*);

	bind afu_control afu_control_asserts i_afu_control_asserts (
		.clock(clock),
		.rstn(rstn),
		.busy(i_tag_table.busy),
		.host_command(host_command),
		.rsp_out(rsp_out),
		.rsp_ready(rsp_ready)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

////////////////////////////////////////////////////////////////////////////
// checking helpers
////////////////////////////////////////////////////////////////////////////

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "check failed");
	endtask

	task automatic compare_command(input string name, input cmd_pkg::host_command_t expected,
			input cmd_pkg::host_command_t actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "command mismatch");
		end
	endtask

	task automatic compare_response(input string name, input rsp_pkg::response_line_t expected,
			input rsp_pkg::response_line_t actual);
		if (expected !== actual) begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "response mismatch");
		end
	endtask

	// galois form with taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return (s >> 1) ^ (s[0] ? 8'hB8 : 8'h00);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic int waiting_for(input int s);
		int n;
		n = 0;
		foreach (exp_cmds[i]) if (exp_cmds[i].address[13:12] == s) n++;
		foreach (exp_rsps[i]) if (exp_rsps[i].address[13:12] == s) n++;
		return n;
	endfunction

////////////////////////////////////////////////////////////////////////////
// host model and output monitors
////////////////////////////////////////////////////////////////////////////

	task automatic record_issue(input cmd_pkg::host_command_t c);
		int idx;
		int src;
		cmd_pkg::host_command_t exp;
		src = int'(c.address[13:12]);
		idx = -1;
		if (quiet) fail_now("host command issued while disabled");
		if (outstanding[c.tag]) fail_now($sformatf("tag %0d issued twice", c.tag));
		foreach (exp_cmds[i]) if (idx < 0 && exp_cmds[i].address[13:12] == src) idx = i;
		if (idx < 0) fail_now($sformatf("unexpected host command for address %h", c.address));
		exp = '{1'b1, exp_cmds[idx].code, c.tag, exp_cmds[idx].address};
		compare_command($sformatf("issue from source %0d", src), exp, c);
		exp_cmds.delete(idx);
		outstanding[c.tag] = 1'b1;
		pend_tag.push_back(c.tag);
		pend_addr.push_back(c.address);
		pend_due.push_back(cycle + delay_of[c.address]);
		issued_count++;
		if (rr_check) begin
			if (have_last && src != (last_src + 1) % `AFU_NUM_SOURCES)
				fail_now($sformatf("[FAIL] round-robin after source %0d expected %0d actual %0d",
					last_src, (last_src + 1) % `AFU_NUM_SOURCES, src));
			last_src  = src;
			have_last = 1'b1;
		end
	endtask

	task automatic send_response();
		int elig [$];
		int pick;
		logic [15:0] addr;
		rsp_pkg::rsp_code_t rc;
		foreach (pend_due[i]) if (pend_due[i] <= cycle) elig.push_back(i);
		if (elig.size() == 0) return;
		// shuffle the answer order among due commands
		pick = elig[take_bits(3) % elig.size()];
		addr = pend_addr[pick];
		rc   = code_of[addr];
		host_response <= '{1'b1, pend_tag[pick], rc};
		exp_rsps.push_back('{1'b1, rc, rc != rsp_pkg::RSP_DONE, addr});
		outstanding[pend_tag[pick]] = 1'b0;
		pend_tag.delete(pick);
		pend_addr.delete(pick);
		pend_due.delete(pick);
	endtask

	always @(posedge clock) begin
		if (rstn) begin
			host_response <= '0;
			if (host_command.valid) record_issue(host_command);
			if (inject_bogus) host_response <= '{1'b1, 3'd0, rsp_pkg::RSP_DONE};
			else if (!silent && enabled) send_response();
			for (int s = 0; s < `AFU_NUM_SOURCES; s++) begin
				if (quiet && rsp_out[s].valid) fail_now("response appeared while disabled");
				if (rsp_out[s].valid && rsp_ready[s]) begin
					int idx;
					idx = -1;
					foreach (exp_rsps[i]) if (idx < 0 && exp_rsps[i].address[13:12] == s) idx = i;
					if (idx < 0) fail_now($sformatf("unexpected response on source %0d", s));
					compare_response($sformatf("response on source %0d", s), exp_rsps[idx],
						rsp_out[s]);
					exp_rsps.delete(idx);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1, "timeout");
		end
	end

////////////////////////////////////////////////////////////////////////////
// stimulus
////////////////////////////////////////////////////////////////////////////

	task automatic push_command(input int src, input cmd_pkg::cmd_code_t code,
			input logic [15:0] addr, input rsp_pkg::rsp_code_t rc, input int delay);
		cmd_pkg::command_line_t line;
		line = '{1'b1, code, addr};
		exp_cmds.push_back(line);
		code_of[addr]  = rc;
		delay_of[addr] = delay;
		@(posedge clock);
		while (!cmd_ready[src]) @(posedge clock);
		cmd_in[src] <= line;
		@(posedge clock);
		cmd_in[src] <= '0;
	endtask

	task automatic wait_drain();
		while (exp_cmds.size() != 0 || exp_rsps.size() != 0 || pend_tag.size() != 0)
			@(posedge clock);
	endtask

	initial begin
		// source, code, address, response, delay, hold
		table_rows[0]  = '{2'd0, cmd_pkg::CMD_READ_LINE,  16'h0010, rsp_pkg::RSP_DONE,    4'd3, 1'b0};
		table_rows[1]  = '{2'd1, cmd_pkg::CMD_WRITE_LINE, 16'h1020, rsp_pkg::RSP_DONE,    4'd1, 1'b0};
		table_rows[2]  = '{2'd2, cmd_pkg::CMD_READ_LINE,  16'h2030, rsp_pkg::RSP_AERROR,  4'd2, 1'b1};
		table_rows[3]  = '{2'd0, cmd_pkg::CMD_WRITE_LINE, 16'h0041, rsp_pkg::RSP_DERROR,  4'd5, 1'b0};
		table_rows[4]  = '{2'd2, cmd_pkg::CMD_WRITE_LINE, 16'h2052, rsp_pkg::RSP_DONE,    4'd1, 1'b1};
		table_rows[5]  = '{2'd1, cmd_pkg::CMD_READ_LINE,  16'h1063, rsp_pkg::RSP_NLOCK,   4'd4, 1'b0};
		table_rows[6]  = '{2'd0, cmd_pkg::CMD_READ_LINE,  16'h0074, rsp_pkg::RSP_DONE,    4'd2, 1'b0};
		table_rows[7]  = '{2'd1, cmd_pkg::CMD_WRITE_LINE, 16'h1085, rsp_pkg::RSP_NRES,    4'd6, 1'b0};
		table_rows[8]  = '{2'd2, cmd_pkg::CMD_READ_LINE,  16'h2096, rsp_pkg::RSP_FAILED,  4'd3, 1'b1};
		table_rows[9]  = '{2'd0, cmd_pkg::CMD_WRITE_LINE, 16'h00A7, rsp_pkg::RSP_PAGED,   4'd1, 1'b0};
		table_rows[10] = '{2'd1, cmd_pkg::CMD_READ_LINE,  16'h10B8, rsp_pkg::RSP_DONE,    4'd2, 1'b0};
		table_rows[11] = '{2'd0, cmd_pkg::CMD_READ_LINE,  16'h00C9, rsp_pkg::RSP_FAULT,   4'd4, 1'b0};
		table_rows[12] = '{2'd2, cmd_pkg::CMD_WRITE_LINE, 16'h20DA, rsp_pkg::RSP_FLUSHED, 4'd2, 1'b1};
		table_rows[13] = '{2'd1, cmd_pkg::CMD_WRITE_LINE, 16'h10EB, rsp_pkg::RSP_DONE,    4'd5, 1'b0};
		table_rows[14] = '{2'd0, cmd_pkg::CMD_WRITE_LINE, 16'h00FC, rsp_pkg::RSP_DONE,    4'd1, 1'b0};
		table_rows[15] = '{2'd2, cmd_pkg::CMD_READ_LINE,  16'h210D, rsp_pkg::RSP_DONE,    4'd6, 1'b1};
		table_rows[16] = '{2'd1, cmd_pkg::CMD_READ_LINE,  16'h111E, rsp_pkg::RSP_AERROR,  4'd3, 1'b0};
		table_rows[17] = '{2'd0, cmd_pkg::CMD_READ_LINE,  16'h012F, rsp_pkg::RSP_DONE,    4'd2, 1'b0};

		rstn          = 1'b0;
		enabled       = 1'b0;
		host_response = '0;
		rsp_ready     = '1;
		for (int s = 0; s < `AFU_NUM_SOURCES; s++) cmd_in[s] = '0;
		lfsr          = 8'd13;
		cycle         = 0;
		issued_count  = 0;
		last_src      = 0;
		have_last     = 1'b0;
		outstanding   = '0;
		silent        = 1'b0;
		rr_check      = 1'b0;
		quiet         = 1'b0;
		inject_bogus  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		if (cmd_ready !== '1) fail_now("cmd_ready not high for every source after reset");
		rstn    <= 1'b1;
		enabled <= 1'b1;

		// table pass with source 2 held back
		for (int r = 0; r < NUM_ROWS; r++) begin
			rsp_ready[table_rows[r].source] <= !table_rows[r].hold;
			push_command(int'(table_rows[r].source), table_rows[r].code, table_rows[r].address,
				table_rows[r].rsp_code, int'(table_rows[r].delay));
		end
		while (waiting_for(0) != 0 || waiting_for(1) != 0 || pend_tag.size() != 0)
			@(posedge clock);
		if (!rsp_out[2].valid) fail_now("held source 2 shows no waiting response");
		rsp_ready <= '1;
		wait_drain();

		// all queues loaded while the host stays silent
		enabled <= 1'b0;
		silent  <= 1'b1;
		for (int i = 0; i < 12; i++)
			push_command(i % 3, cmd_pkg::CMD_READ_LINE, 16'h0800 + 16'(i / 3) + 16'((i % 3) << 12),
				rsp_pkg::RSP_DONE, 2);
		issued_count = 0;
		have_last    = 1'b0;
		rr_check    <= 1'b1;
		enabled     <= 1'b1;
		while (issued_count < `AFU_NUM_TAGS) @(posedge clock);
		repeat (10) @(posedge clock);
		if (issued_count != `AFU_NUM_TAGS)
			fail_now($sformatf("[FAIL] issues with the host silent expected %0d actual %0d",
				`AFU_NUM_TAGS, issued_count));
		silent <= 1'b0;
		wait_drain();
		rr_check <= 1'b0;

		// full command queue and disabled behavior
		enabled <= 1'b0;
		for (int i = 0; i < `AFU_CMD_DEPTH; i++)
			push_command(1, cmd_pkg::CMD_WRITE_LINE, 16'h1900 + 16'(i), rsp_pkg::RSP_PAGED, 1);
		@(posedge clock);
		if (cmd_ready[1]) fail_now("cmd_ready stayed high with a full command queue");
		quiet        <= 1'b1;
		inject_bogus <= 1'b1;
		@(posedge clock);
		inject_bogus <= 1'b0;
		repeat (8) @(posedge clock);
		quiet   <= 1'b0;
		enabled <= 1'b1;
		wait_drain();
		repeat (4) @(posedge clock);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
